//--- ahb_slv_sif/ahb_slv_sif.sv
// ahb-lite slave front end, widths 32/32 64/32 64/64 only, sub-word writes zero-extended, no strobes
`timescale 1ns/1ns
`default_nettype none

module ahb_slv_sif #(
    parameter int AHB_DATA_WIDTH    = ahb_defines_pkg::AHB_DW,
    parameter int CLIENT_DATA_WIDTH = ahb_defines_pkg::CLIENT_DW,
    parameter int AHB_ADDR_WIDTH    = ahb_defines_pkg::AHB_AW,
    parameter int CLIENT_ADDR_WIDTH = AHB_ADDR_WIDTH
) (
    input  wire logic                         hclk,
    input  wire logic                         hreset_n,
    // ahb-lite slave side
    input  wire logic [AHB_ADDR_WIDTH-1:0]    haddr_i,
    input  wire logic [AHB_DATA_WIDTH-1:0]    hwdata_i,
    input  wire logic                         hsel_i,
    input  wire logic                         hwrite_i,
    input  wire logic                         hready_i,
    input  wire logic [1:0]                   htrans_i,
    input  wire logic [2:0]                   hsize_i,
    output logic                              hresp_o,
    output logic                              hreadyout_o,
    output logic [AHB_DATA_WIDTH-1:0]         hrdata_o,
    // client side
    output logic                              dv_o,
    output logic                              write_o,
    output logic [CLIENT_DATA_WIDTH-1:0]      wdata_o,
    output logic [CLIENT_ADDR_WIDTH-1:0]      addr_o,
    input  wire logic                         hld_i,
    input  wire logic                         err_i,
    input  wire logic [CLIENT_DATA_WIDTH-1:0] rdata_i
);
    import ahb_defines_pkg::*;

    logic [2:0] size_q; // data-phase hsize
    logic       err_f;  // second error cycle pending

    // write steering and read placement per width combination
    generate
        if ((AHB_DATA_WIDTH == 32) && (CLIENT_DATA_WIDTH == 32)) begin : g_32_32
            always_comb begin
                case (size_q)
                    HSIZE_BYTE: wdata_o = {24'b0, hwdata_i[7:0]};
                    HSIZE_HALF: wdata_o = {16'b0, hwdata_i[15:0]};
                    default:    wdata_o = hwdata_i[31:0];
                endcase
            end
            assign hrdata_o = rdata_i; // single lane
        end else if ((AHB_DATA_WIDTH == 64) && (CLIENT_DATA_WIDTH == 32)) begin : g_64_32
            logic [31:0] wr_lane;

            assign wr_lane = addr_o[2] ? hwdata_i[63:32] : hwdata_i[31:0]; // lane by addr bit 2

            always_comb begin
                case (size_q)
                    HSIZE_BYTE: wdata_o = {24'b0, wr_lane[7:0]};
                    HSIZE_HALF: wdata_o = {16'b0, wr_lane[15:0]};
                    default:    wdata_o = wr_lane; // word and wider sizes clipped
                endcase
            end

            // unused lane reads zero
            assign hrdata_o = addr_o[2] ? {rdata_i, 32'b0} : {32'b0, rdata_i};
        end else if ((AHB_DATA_WIDTH == 64) && (CLIENT_DATA_WIDTH == 64)) begin : g_64_64
            logic [31:0] wr_word;

            assign wr_word = addr_o[2] ? hwdata_i[63:32] : hwdata_i[31:0];

            always_comb begin
                case (size_q)
                    HSIZE_BYTE:  wdata_o = {56'b0, hwdata_i[7:0]};
                    HSIZE_HALF:  wdata_o = {48'b0, hwdata_i[15:0]};
                    HSIZE_WORD:  wdata_o = {32'b0, wr_word};
                    HSIZE_DWORD: wdata_o = hwdata_i;
                    default:     wdata_o = hwdata_i;
                endcase
            end
            assign hrdata_o = rdata_i;
        end
    endgenerate

    // address phase captured and held through wait states
    always_ff @(posedge hclk or negedge hreset_n) begin
        if (!hreset_n) begin
            dv_o    <= 1'b0;
            write_o <= 1'b0;
            addr_o  <= '0;
            size_q  <= HSIZE_BYTE;
            err_f   <= 1'b0;
        end else begin
            err_f <= err_i & ~err_f; // one pending flag per error transfer
            if (hready_i) begin
                dv_o <= hsel_i & ((htrans_i == HTRANS_NONSEQ) || (htrans_i == HTRANS_SEQ));
            end
            if (hready_i && hsel_i) begin
                addr_o  <= haddr_i[CLIENT_ADDR_WIDTH-1:0];
                write_o <= hwrite_i; // only acted on together with dv
                size_q  <= hsize_i;
            end
        end
    end

    // response
    // error takes two cycles with ready low then high
    always_comb begin
        hreadyout_o = 1'b1;
        hresp_o     = H_OKAY;
        if (err_i && !err_f) begin
            hreadyout_o = 1'b0; // first error cycle
            hresp_o     = H_ERROR;
        end else if (err_f) begin
            hreadyout_o = 1'b1; // error completes
            hresp_o     = H_ERROR;
        end else if (dv_o && hld_i) begin
            hreadyout_o = 1'b0; // client wait state
            hresp_o     = H_OKAY;
        end
    end

endmodule : ahb_slv_sif

`default_nettype wire

//--- common/ahb_defines_pkg.sv
// shared ahb-lite codes and register map, 64-bit bus over a 32-bit client, no retry/split, no hprot
`default_nettype none

package ahb_defines_pkg;

    // hresp, okay and error only
    localparam logic H_OKAY  = 1'b0;
    localparam logic H_ERROR = 1'b1;

    // htrans
    localparam logic [1:0] HTRANS_IDLE   = 2'b00;
    localparam logic [1:0] HTRANS_BUSY   = 2'b01; // accepted on the bus, never a valid access
    localparam logic [1:0] HTRANS_NONSEQ = 2'b10;
    localparam logic [1:0] HTRANS_SEQ    = 2'b11;

    // hsize
    localparam logic [2:0] HSIZE_BYTE  = 3'b000;
    localparam logic [2:0] HSIZE_HALF  = 3'b001;
    localparam logic [2:0] HSIZE_WORD  = 3'b010;
    localparam logic [2:0] HSIZE_DWORD = 3'b011; // 64-bit client only

    // bus and client widths
    localparam int AHB_DW    = 64;
    localparam int AHB_AW    = 32;
    localparam int CLIENT_DW = 32;

    // register map
    // 0x00-0x3f fast, 0x40-0x7f slow, 0x80 and up unmapped
    localparam int REG_COUNT     = 32;
    localparam int REG_IDX_W     = 5;  // client addr 6:2
    localparam int SLOW_BIT      = 6;
    localparam int MAP_LIMIT_BIT = 7;

    // hld cycles per slow access
    localparam int WAIT_CYCLES = 2;

    // one register write, decoder to bank
    typedef struct packed {
        logic                 wr_en;
        logic [REG_IDX_W-1:0] idx;
        logic [CLIENT_DW-1:0] data;
    } reg_wr_t;

endpackage : ahb_defines_pkg

`default_nettype wire

//--- testbench/tb_ahb_reg_top.sv
// single-master single-slave ahb-lite test, hready tied to hreadyout, lfsr stimulus from a fixed seed
`timescale 1ns/1ns
`default_nettype none

module tb_ahb_reg_top;
    import ahb_defines_pkg::*;

    localparam int          CLK_PERIOD   = 100;
    localparam logic [31:0] LFSR_SEED    = 32'h5e67d019;
    localparam int          NUM_RANDOM   = 400;
    localparam int          NUM_DIRECTED = 17;
    localparam int          NUM_XFERS    = NUM_RANDOM + 2 * REG_COUNT + NUM_DIRECTED;
    localparam int          WATCHDOG_NS  = (NUM_XFERS * (WAIT_CYCLES + 3) + 50) * CLK_PERIOD;

    // one bus transfer as the master sees it
    typedef struct packed {
        logic        sel;
        logic [1:0]  trans;
        logic        write;
        logic [31:0] addr;
        logic [2:0]  size;
        logic [63:0] wdata;
    } xfer_t;

    logic              hclk;
    logic              hreset_n;
    logic [AHB_AW-1:0] haddr;
    logic [AHB_DW-1:0] hwdata;
    logic [AHB_DW-1:0] hrdata;
    logic              hsel;
    logic              hwrite;
    logic              hready;
    logic              hreadyout;
    logic              hresp;
    logic [1:0]        htrans;
    logic [2:0]        hsize;

    logic [31:0] model_regs [REG_COUNT]; // expected register contents
    logic [31:0] lfsr_state;
    xfer_t       xfer_q [$];             // transfers waiting for their address phase

    assign hready = hreadyout; // only slave on the bus

    tb_clkgen #(
        .PERIOD_NS    (CLK_PERIOD),
        .RESET_CYCLES (2)
    ) u_clkgen (
        .hclk_o     (hclk),
        .hreset_n_o (hreset_n)
    );

    ahb_reg_top u_dut (
        .hclk        (hclk),
        .hreset_n    (hreset_n),
        .haddr_i     (haddr),
        .hwdata_i    (hwdata),
        .hsel_i      (hsel),
        .hwrite_i    (hwrite),
        .hready_i    (hready),
        .htrans_i    (htrans),
        .hsize_i     (hsize),
        .hrdata_o    (hrdata),
        .hreadyout_o (hreadyout),
        .hresp_o     (hresp)
    );

    // x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        logic fb;
        fb = s[31] ^ s[21] ^ s[1] ^ s[0];
        return {s[30:0], fb};
    endfunction

    // one lfsr step per bit taken
    function automatic logic [63:0] take_bits(input int n);
        logic [63:0] val;
        val = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = lfsr_step(lfsr_state);
            val        = {val[62:0], lfsr_state[0]};
        end
        return val;
    endfunction

    function automatic logic is_access(input xfer_t t);
        return t.sel && ((t.trans == HTRANS_NONSEQ) || (t.trans == HTRANS_SEQ));
    endfunction

    function automatic logic is_unmapped(input logic [31:0] addr);
        return addr >= 32'h80;
    endfunction

    // ready expected in data-phase cycle cyc counted from 0
    function automatic logic ready_expected(input xfer_t t, input int cyc);
        if (!is_access(t)) return 1'b1;
        if (is_unmapped(t.addr)) return cyc >= 1;         // two-cycle error
        if (t.addr >= 32'h40) return cyc >= WAIT_CYCLES;  // slow region
        return 1'b1;
    endfunction

    function automatic logic resp_expected(input xfer_t t);
        return (is_access(t) && is_unmapped(t.addr)) ? H_ERROR : H_OKAY;
    endfunction

    // lane by addr bit 2, then zero-extended by size
    function automatic logic [31:0] stored_value(input xfer_t t);
        logic [31:0] lane;
        lane = t.addr[2] ? t.wdata[63:32] : t.wdata[31:0];
        case (t.size)
            HSIZE_BYTE: return {24'h0, lane[7:0]};
            HSIZE_HALF: return {16'h0, lane[15:0]};
            default:    return lane;
        endcase
    endfunction

    function automatic logic [63:0] read_expected(input logic [31:0] addr);
        logic [31:0] word;
        word = model_regs[addr[6:2]];
        return addr[2] ? {word, 32'h0} : {32'h0, word}; // other lane zero
    endfunction

    task automatic abort_run(input string reason);
        $display("%s", reason);
        $display("sim failed");
        $fatal(1, "run stopped on the first error");
    endtask

    task automatic check_value(input logic [63:0] actual, input logic [63:0] expected,
                               input string what);
        if (actual !== expected) begin
            abort_run($sformatf("FAIL %0t ns: %s got %h expected %h",
                                $time, what, actual, expected));
        end
    endtask

    task automatic queue_write(input logic [31:0] addr, input logic [2:0] size,
                               input logic [63:0] data);
        xfer_q.push_back('{sel: 1'b1, trans: HTRANS_NONSEQ, write: 1'b1, addr: addr,
                           size: size, wdata: data});
    endtask

    task automatic queue_read(input logic [31:0] addr);
        xfer_q.push_back('{sel: 1'b1, trans: HTRANS_NONSEQ, write: 1'b0, addr: addr,
                           size: HSIZE_WORD, wdata: take_bits(64)});
    endtask

    // idle with hsel high, or a nonseq write with hsel low
    task automatic queue_no_access(input logic sel);
        xfer_q.push_back('{sel: sel, trans: sel ? HTRANS_IDLE : HTRANS_NONSEQ, write: 1'b1,
                           addr: 32'h0, size: HSIZE_WORD, wdata: take_bits(64)});
    endtask

    task automatic queue_random();
        xfer_t       t;
        logic [63:0] r;
        t.sel = take_bits(3) != 0;                   // deselected one time in eight
        r = take_bits(3);
        if (r[2:0] == 3'd0) begin
            t.trans = HTRANS_IDLE;
        end else if (r[0]) begin
            t.trans = HTRANS_NONSEQ;
        end else begin
            t.trans = HTRANS_SEQ;
        end
        if (take_bits(4) == 0) begin
            r      = take_bits(32);
            t.addr = r[31:0] | 32'h80;               // unmapped
        end else begin
            r      = take_bits(7);
            t.addr = {25'h0, r[6:0]};                // fast or slow
        end
        r = take_bits(2);
        case (r[1:0])
            2'd0:    t.size = HSIZE_BYTE;
            2'd1:    t.size = HSIZE_HALF;
            default: t.size = HSIZE_WORD;
        endcase
        if (t.size == HSIZE_HALF) t.addr[0] = 1'b0;  // natural alignment
        if (t.size == HSIZE_WORD) t.addr[1:0] = 2'b00;
        t.write = take_bits(1) != 0;
        t.wdata = take_bits(64);
        xfer_q.push_back(t);
    endtask

    task automatic drive_address(input xfer_t t);
        haddr  <= t.addr;
        hsel   <= t.sel;
        htrans <= t.trans;
        hwrite <= t.write;
        hsize  <= t.size;
    endtask

    // data-phase completion updates the model or checks a read
    task automatic retire(input xfer_t t);
        if (is_access(t) && !is_unmapped(t.addr)) begin
            if (t.write) begin
                model_regs[t.addr[6:2]] = stored_value(t);
            end else begin
                check_value(hrdata, read_expected(t.addr),
                            $sformatf("hrdata read of %h", t.addr));
            end
        end
    endtask

    // pipelined master samples at negedge and advances on a ready rising edge
    task automatic run_queue();
        xfer_t ap;
        xfer_t dp;
        int    dp_cycle;
        int    steps;
        int    total;
        logic  ready;
        ap       = '0;                 // idle like the bus between runs
        dp       = '0;
        dp_cycle = 0;
        steps    = 0;
        total    = xfer_q.size() + 2;  // two extra steps drain the pipeline
        while (steps < total) begin
            @(negedge hclk);
            ready = hreadyout;
            check_value(ready, ready_expected(dp, dp_cycle),
                        $sformatf("hreadyout at %h cycle %0d", dp.addr, dp_cycle));
            check_value(hresp, resp_expected(dp),
                        $sformatf("hresp at %h cycle %0d", dp.addr, dp_cycle));
            if (ready) retire(dp);
            @(posedge hclk);
            if (ready) begin
                dp       = ap;
                dp_cycle = 0;
                if (xfer_q.size() > 0) begin
                    ap = xfer_q.pop_front();
                end else begin
                    ap = '0;
                end
                drive_address(ap);
                hwdata <= dp.wdata;    // data phase of the transfer just accepted
                steps++;
            end else begin
                dp_cycle++;            // wait state holds the bus
            end
        end
    endtask

    initial begin
        #(WATCHDOG_NS);
        abort_run($sformatf("timeout after %0d ns, the transfers never finished", WATCHDOG_NS));
    end

    initial begin
        for (int i = 0; i < REG_COUNT; i++) begin
            model_regs[i] = '0;
        end
        lfsr_state = LFSR_SEED;
        haddr  <= '0;
        hwdata <= '0;
        hsel   <= 1'b0;
        htrans <= HTRANS_IDLE;
        hwrite <= 1'b0;
        hsize  <= HSIZE_WORD;
        wait (hreset_n === 1'b1);

        // every register reads zero after reset
        for (int i = 0; i < REG_COUNT; i++) begin
            queue_read(32'(i * 4));
        end
        run_queue();

        queue_write(32'h0c, HSIZE_WORD, take_bits(64)); // upper lane word
        queue_read(32'h0c);
        queue_write(32'h10, HSIZE_WORD, take_bits(64)); // lower lane word
        queue_read(32'h10);
        queue_write(32'h15, HSIZE_BYTE, take_bits(64));
        queue_read(32'h14);
        queue_write(32'h1a, HSIZE_HALF, take_bits(64));
        queue_read(32'h18);
        queue_write(32'h44, HSIZE_WORD, take_bits(64)); // slow writes back to back
        queue_write(32'h4c, HSIZE_WORD, take_bits(64));
        queue_read(32'h44);
        queue_read(32'h4c);
        queue_write(32'h80, HSIZE_WORD, take_bits(64)); // unmapped write aliasing index 0
        queue_read(32'h00);
        queue_no_access(1'b1);
        queue_no_access(1'b0);
        queue_read(32'h00);
        run_queue();

        repeat (NUM_RANDOM) queue_random();
        run_queue();

        // final sweep against the model
        for (int i = 0; i < REG_COUNT; i++) begin
            queue_read(32'(i * 4));
        end
        run_queue();

        $display("sim passed");
        $finish;
    end

endmodule : tb_ahb_reg_top

`default_nettype wire

//--- testbench/tb_clkgen.sv
// testbench clock and reset source, reset releases on a rising edge after RESET_CYCLES edges
`timescale 1ns/1ns
`default_nettype none

module tb_clkgen #(
    parameter int PERIOD_NS    = 100,
    parameter int RESET_CYCLES = 2
) (
    output logic hclk_o,
    output logic hreset_n_o
);

    // free-running clock, starts low
    initial begin
        hclk_o = 1'b0;
        forever #(PERIOD_NS / 2) hclk_o = ~hclk_o;
    end

    initial begin
        hreset_n_o = 1'b0;                   // in reset from time zero
        repeat (RESET_CYCLES) @(posedge hclk_o);
        hreset_n_o <= 1'b1;                  // release with the edge, like any other input
    end

endmodule : tb_clkgen

`default_nettype wire

//--- verilog.f
common/ahb_defines_pkg.sv
ahb_slv_sif/ahb_slv_sif.sv
verilog/client_decode.sv
verilog/wait_ctrl.sv
verilog/reg_bank.sv
verilog/ahb_reg_top.sv
testbench/tb_clkgen.sv
testbench/tb_ahb_reg_top.sv

//--- verilog/ahb_reg_top.sv
// ahb-lite register block top, master must tie hready_i to hreadyout_o when it is the only slave
`timescale 1ns/1ns
`default_nettype none

module ahb_reg_top (
    input  wire logic                                  hclk,
    input  wire logic                                  hreset_n,
    input  wire logic [ahb_defines_pkg::AHB_AW-1:0]    haddr_i,
    input  wire logic [ahb_defines_pkg::AHB_DW-1:0]    hwdata_i,
    input  wire logic                                  hsel_i,
    input  wire logic                                  hwrite_i,
    input  wire logic                                  hready_i,
    input  wire logic [1:0]                            htrans_i,
    input  wire logic [2:0]                            hsize_i,
    output logic [ahb_defines_pkg::AHB_DW-1:0]         hrdata_o,
    output logic                                       hreadyout_o,
    output logic                                       hresp_o
);
    import ahb_defines_pkg::*;

    // client port
    logic                 dv;
    logic                 write;
    logic [AHB_AW-1:0]    addr;
    logic [CLIENT_DW-1:0] wdata;
    logic [CLIENT_DW-1:0] rdata;
    logic                 hld;
    logic                 err;

    // decode to bank and wait counter
    logic                 slow_req;
    reg_wr_t              reg_wr;
    logic [REG_IDX_W-1:0] rd_idx;

    ahb_slv_sif #(
        .AHB_DATA_WIDTH    (AHB_DW),
        .CLIENT_DATA_WIDTH (CLIENT_DW),
        .AHB_ADDR_WIDTH    (AHB_AW),
        .CLIENT_ADDR_WIDTH (AHB_AW)
    ) u_sif (
        .hclk        (hclk),
        .hreset_n    (hreset_n),
        .haddr_i     (haddr_i),
        .hwdata_i    (hwdata_i),
        .hsel_i      (hsel_i),
        .hwrite_i    (hwrite_i),
        .hready_i    (hready_i),
        .htrans_i    (htrans_i),
        .hsize_i     (hsize_i),
        .hresp_o     (hresp_o),
        .hreadyout_o (hreadyout_o),
        .hrdata_o    (hrdata_o),
        .dv_o        (dv),
        .write_o     (write),
        .wdata_o     (wdata),
        .addr_o      (addr),
        .hld_i       (hld),
        .err_i       (err),
        .rdata_i     (rdata)
    );

    client_decode u_decode (
        .dv_i       (dv),
        .write_i    (write),
        .addr_i     (addr),
        .wdata_i    (wdata),
        .hld_i      (hld),
        .err_o      (err),
        .slow_req_o (slow_req),
        .reg_wr_o   (reg_wr),
        .rd_idx_o   (rd_idx)
    );

    wait_ctrl #(
        .WAIT_CYCLES (WAIT_CYCLES)
    ) u_wait (
        .hclk       (hclk),
        .hreset_n   (hreset_n),
        .slow_req_i (slow_req),
        .hld_o      (hld)
    );

    reg_bank u_regs (
        .hclk      (hclk),
        .hreset_n  (hreset_n),
        .reg_wr_i  (reg_wr),
        .rd_idx_i  (rd_idx),
        .rd_data_o (rdata)
    );

endmodule : ahb_reg_top

`default_nettype wire

//--- verilog/client_decode.sv
// client address decode, regions are fixed by the package map, only bits 6:2 pick the register
`timescale 1ns/1ns
`default_nettype none

module client_decode (
    input  wire logic                                        dv_i,
    input  wire logic                                        write_i,
    input  wire logic [ahb_defines_pkg::AHB_AW-1:0]          addr_i,
    input  wire logic [ahb_defines_pkg::CLIENT_DW-1:0]       wdata_i,
    input  wire logic                                        hld_i,
    output logic                                             err_o,
    output logic                                             slow_req_o,
    output ahb_defines_pkg::reg_wr_t                         reg_wr_o,
    output logic [ahb_defines_pkg::REG_IDX_W-1:0]            rd_idx_o
);
    import ahb_defines_pkg::*;

    logic                 unmapped;
    logic                 slow;
    logic [REG_IDX_W-1:0] idx;

    // region split
    assign unmapped = |addr_i[AHB_AW-1:MAP_LIMIT_BIT]; // 0x80 and up
    assign slow     = addr_i[SLOW_BIT] & ~unmapped;     // 0x40-0x7f
    assign idx      = addr_i[SLOW_BIT:2];               // word index across both regions

    assign err_o      = dv_i & unmapped;
    assign slow_req_o = dv_i & slow;

    // write lands in the completing cycle only
    always_comb begin
        reg_wr_o.wr_en = dv_i & write_i & ~unmapped & ~hld_i;
        reg_wr_o.idx   = idx;
        reg_wr_o.data  = wdata_i;
    end

    assign rd_idx_o = idx; // read path is combinational in the bank

endmodule : client_decode

`default_nettype wire

//--- verilog/reg_bank.sv
// 32 x 32-bit register file, one write port, combinational read, registers reset to zero
`timescale 1ns/1ns
`default_nettype none

module reg_bank (
    input  wire logic                                  hclk,
    input  wire logic                                  hreset_n,
    input  wire ahb_defines_pkg::reg_wr_t              reg_wr_i,
    input  wire logic [ahb_defines_pkg::REG_IDX_W-1:0] rd_idx_i,
    output logic [ahb_defines_pkg::CLIENT_DW-1:0]      rd_data_o
);
    import ahb_defines_pkg::*;

    logic [CLIENT_DW-1:0] regs [REG_COUNT];

    // write port
    always_ff @(posedge hclk or negedge hreset_n) begin
        if (!hreset_n) begin
            for (int i = 0; i < REG_COUNT; i++) begin
                regs[i] <= '0;
            end
        end else if (reg_wr_i.wr_en) begin
            regs[reg_wr_i.idx] <= reg_wr_i.data; // wait states already filtered by decode
        end
    end

    assign rd_data_o = regs[rd_idx_i]; // same-cycle read

endmodule : reg_bank

`default_nettype wire

//--- verilog/wait_ctrl.sv
// wait-state counter for slow accesses, WAIT_CYCLES must be 1 or more
`timescale 1ns/1ns
`default_nettype none

module wait_ctrl #(
    parameter int WAIT_CYCLES = ahb_defines_pkg::WAIT_CYCLES
) (
    input  wire logic hclk,
    input  wire logic hreset_n,
    input  wire logic slow_req_i,
    output logic      hld_o
);
    localparam int CNT_W = (WAIT_CYCLES > 1) ? $clog2(WAIT_CYCLES) : 1;

    logic [CNT_W-1:0] cnt;    // remaining held cycles after the first
    logic             active; // request already counted

    // first cycle holds before the counter loads
    assign hld_o = slow_req_i & (~active | (cnt != '0));

    always_ff @(posedge hclk or negedge hreset_n) begin
        if (!hreset_n) begin
            cnt    <= '0;
            active <= 1'b0;
        end else if (!slow_req_i) begin
            cnt    <= '0; // request gone, start over
            active <= 1'b0;
        end else if (!active) begin
            cnt    <= CNT_W'(WAIT_CYCLES - 1); // new slow request
            active <= 1'b1;
        end else if (cnt != '0) begin
            cnt <= cnt - 1'b1;
        end else begin
            active <= 1'b0; // completing cycle, ready for a back-to-back request
        end
    end

endmodule : wait_ctrl

`default_nettype wire
